// ==== rtl/keypad_lcd_pkg.sv ====
`default_nettype none

package keypad_lcd_pkg;

    //////////////////////////////////////////////////
    // types shared by the keypad, LCD and I2C blocks

    typedef logic [3:0] key_t;

    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] data;
    } i2c_frame_t;

    // one backpack data byte, msb first
    typedef struct packed {
        logic [3:0] nibble;
        logic       backlight;
        logic       en;
        logic       rw;
        logic       rs;
    } lcd_ctrl_t;

    //////////////////////////////////////////////////
    // constants, sized for simulation

    localparam logic [6:0] lcd_addr      = 7'h27;
    localparam logic [7:0] scan_clks     = 8'd16;
    localparam logic [3:0] i2c_half_clks = 4'd4;
    localparam int         num_cols      = 4;
    localparam int         num_rows      = 4;
    localparam logic       lcd_backlight = 1'b1;
    localparam int         frames_per_char = 5;

    // index is col * 4 + row, legend as printed on the pad
    localparam key_t key_map [0:15] = '{
        4'hd, 4'hf, 4'h0, 4'hc,
        4'he, 4'h3, 4'h2, 4'h1,
        4'hb, 4'h6, 4'h5, 4'h4,
        4'ha, 4'h9, 4'h8, 4'h7
    };

endpackage

`default_nettype wire

// ==== rtl/keypad_scanner.sv ====
`timescale 1ns/1ns
`default_nettype none

module keypad_scanner (
    input  logic                 clk,
    input  logic                 reset_p,
    input  logic [3:0]           row,
    output logic [3:0]           col,
    output keypad_lcd_pkg::key_t key_value,
    output logic                 key_valid,
    input  logic                 key_ready
);
    import keypad_lcd_pkg::*;

    typedef enum logic [1:0] {
        st_scan,
        st_offer,
        st_release
    } scan_state_t;

    scan_state_t state;
    logic [7:0]  div_cnt;
    logic        step;
    logic [1:0]  col_idx;
    logic [1:0]  row_idx;
    logic        row_hit;
    logic        capture;

    // scan step divider, free running
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            div_cnt <= '0;
        end else if (step) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

    assign step    = (div_cnt == scan_clks - 8'd1);
    assign col     = 4'b0001 << col_idx;
    assign row_hit = (row != 4'b0000);
    assign capture = step && row_hit && (state == st_scan);

    // lowest set row bit wins
    always_comb begin
        row_idx = '0;
        for (int i = num_rows - 1; i >= 0; i--) begin
            if (row[i]) begin
                row_idx = 2'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // scan / offer / wait for release

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state     <= st_scan;
            col_idx   <= '0;
            key_valid <= 1'b0;
        end else begin
            case (state)
                st_scan: begin
                    if (capture) begin
                        key_valid <= 1'b1;
                        state     <= st_offer;
                    end else if (step) begin
                        col_idx <= (col_idx == 2'(num_cols - 1)) ? 2'd0 : col_idx + 2'd1;
                    end
                end
                st_offer: begin
                    // column stays put until the sender takes the key
                    if (key_ready) begin
                        key_valid <= 1'b0;
                        state     <= st_release;
                    end
                end
                st_release: begin
                    if (step && !row_hit) begin
                        state <= st_scan;
                    end
                end
                default: state <= st_scan;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            key_value <= key_map[{col_idx, row_idx}];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lcd_byte_sender.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcd_byte_sender (
    input  logic                       clk,
    input  logic                       reset_p,
    input  keypad_lcd_pkg::key_t       key_value,
    input  logic                       key_valid,
    output logic                       key_ready,
    output keypad_lcd_pkg::i2c_frame_t frame,
    output logic                       frame_valid,
    input  logic                       frame_ready
);
    import keypad_lcd_pkg::*;

    logic       busy;
    logic [2:0] frame_cnt;
    logic [7:0] ascii;
    logic       last_frame;
    lcd_ctrl_t  ctrl;

    assign key_ready  = !busy;
    assign last_frame = (frame_cnt == 3'(frames_per_char - 1));

    // hex digit to ascii, 'A' onward above 9
    always_ff @(posedge clk) begin
        if (key_valid && key_ready) begin
            if (key_value < 4'd10) begin
                ascii <= 8'h30 + {4'h0, key_value};
            end else begin
                ascii <= 8'h37 + {4'h0, key_value};
            end
        end
    end

    // one frame at a time, valid rises the clock after each transfer
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            busy        <= 1'b0;
            frame_cnt   <= '0;
            frame_valid <= 1'b0;
        end else if (!busy) begin
            if (key_valid) begin
                busy      <= 1'b1;
                frame_cnt <= '0;
            end
        end else if (!frame_valid) begin
            frame_valid <= 1'b1;
        end else if (frame_ready) begin
            frame_valid <= 1'b0;
            if (last_frame) begin
                busy <= 1'b0;
            end else begin
                frame_cnt <= frame_cnt + 3'd1;
            end
        end
    end

    // high nibble twice, then low nibble three times; E pulses on 1 and 3
    always_comb begin
        ctrl.nibble    = (frame_cnt < 3'd2) ? ascii[7:4] : ascii[3:0];
        ctrl.backlight = lcd_backlight;
        ctrl.en        = (frame_cnt == 3'd1) || (frame_cnt == 3'd3);
        ctrl.rw        = 1'b0;
        ctrl.rs        = 1'b1;
    end

    assign frame.addr = lcd_addr;
    assign frame.data = ctrl;

endmodule

`default_nettype wire

// ==== rtl/i2c_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_writer (
    input  logic                       clk,
    input  logic                       reset_p,
    input  keypad_lcd_pkg::i2c_frame_t frame,
    input  logic                       frame_valid,
    output logic                       frame_ready,
    output logic                       scl,
    output logic                       sda
);
    import keypad_lcd_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_addr,
        st_ack_addr,
        st_data,
        st_ack_data,
        st_stop_setup,
        st_stop
    } i2c_state_t;

    i2c_state_t state;
    logic [3:0] half_cnt;
    logic       half_tick;
    logic [2:0] bit_cnt;
    i2c_frame_t frame_q;
    logic [7:0] addr_byte;
    logic       bit_out;

    assign frame_ready = (state == st_idle);
    assign half_tick   = (half_cnt == i2c_half_clks - 4'd1);
    assign addr_byte   = {frame_q.addr, 1'b0};

    always_ff @(posedge clk) begin
        if (frame_valid && frame_ready) begin
            frame_q <= frame;
        end
    end

    // half scl period counter
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            half_cnt <= '0;
        end else if (state == st_idle || half_tick) begin
            half_cnt <= '0;
        end else begin
            half_cnt <= half_cnt + 4'd1;
        end
    end

    // level for sda in the current low half, ack slots stay high
    always_comb begin
        case (state)
            st_addr:       bit_out = addr_byte[bit_cnt];
            st_data:       bit_out = frame_q.data[bit_cnt];
            st_stop_setup: bit_out = 1'b0;
            default:       bit_out = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // bus sequencer, 40 half periods per frame

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state   <= st_idle;
            scl     <= 1'b1;
            sda     <= 1'b1;
            bit_cnt <= '0;
        end else begin
            // sda moves one clock after scl falls
            if (!scl && half_cnt == 4'd0) begin
                sda <= bit_out;
            end
            case (state)
                st_idle: begin
                    if (frame_valid) begin
                        sda   <= 1'b0;
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (half_tick) begin
                        scl     <= 1'b0;
                        bit_cnt <= 3'd7;
                        state   <= st_addr;
                    end
                end
                st_addr, st_data: begin
                    if (half_tick) begin
                        scl <= ~scl;
                        if (scl && bit_cnt == 3'd0) begin
                            state <= (state == st_addr) ? st_ack_addr : st_ack_data;
                        end else if (scl) begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end
                    end
                end
                st_ack_addr: begin
                    if (half_tick) begin
                        scl <= ~scl;
                        if (scl) begin
                            bit_cnt <= 3'd7;
                            state   <= st_data;
                        end
                    end
                end
                st_ack_data: begin
                    if (half_tick) begin
                        scl <= ~scl;
                        if (scl) begin
                            state <= st_stop_setup;
                        end
                    end
                end
                st_stop_setup: begin
                    if (half_tick) begin
                        scl     <= 1'b1;
                        bit_cnt <= 3'd1;
                        state   <= st_stop;
                    end
                end
                st_stop: begin
                    // first half releases sda, second half is bus free time
                    if (half_tick && bit_cnt != 3'd0) begin
                        sda     <= 1'b1;
                        bit_cnt <= 3'd0;
                    end else if (half_tick) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/keypad_lcd_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module keypad_lcd_top (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] row,
    output logic [3:0] col,
    output logic       scl,
    output logic       sda
);
    import keypad_lcd_pkg::*;

    key_t       key_value;
    logic       key_valid;
    logic       key_ready;
    i2c_frame_t frame;
    logic       frame_valid;
    logic       frame_ready;

    // keypad -> lcd byte
    keypad_scanner scanner_i (
        .clk       (clk),
        .reset_p   (reset_p),
        .row       (row),
        .col       (col),
        .key_value (key_value),
        .key_valid (key_valid),
        .key_ready (key_ready)
    );

    lcd_byte_sender sender_i (
        .clk         (clk),
        .reset_p     (reset_p),
        .key_value   (key_value),
        .key_valid   (key_valid),
        .key_ready   (key_ready),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    // lcd byte -> I2C bus
    i2c_writer writer_i (
        .clk         (clk),
        .reset_p     (reset_p),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .scl         (scl),
        .sda         (sda)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset_p
);
    localparam int half_period_ns = 4;
    localparam int reset_cycles   = 16;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        reset_p = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_p = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/i2c_writer_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_writer_assert (
    input logic                       clk,
    input logic                       reset_p,
    input keypad_lcd_pkg::i2c_frame_t frame,
    input logic                       frame_valid,
    input logic                       frame_ready,
    input logic                       scl,
    input logic                       sda
);
    int failures = 0;

    // a pending frame stays offered until the writer takes it
    valid_held: assert property (@(posedge clk) disable iff (reset_p)
        frame_valid && !frame_ready |=> frame_valid)
        else begin
            $error("frame_valid dropped before frame_ready");
            failures = failures + 1;
        end

    frame_stable: assert property (@(posedge clk) disable iff (reset_p)
        frame_valid && !frame_ready |=> $stable(frame))
        else begin
            $error("frame changed while waiting for frame_ready");
            failures = failures + 1;
        end

    // idle writer means an idle bus
    bus_idle: assert property (@(posedge clk) disable iff (reset_p)
        frame_ready |-> scl && sda)
        else begin
            $error("scl or sda low while frame_ready is high");
            failures = failures + 1;
        end

endmodule

bind i2c_writer i2c_writer_assert writer_assert_i (
    .clk         (clk),
    .reset_p     (reset_p),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .scl         (scl),
    .sda         (sda)
);

`default_nettype wire

// ==== verif/keypad_lcd_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module keypad_lcd_checker (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] col,
    input  logic       scl,
    input  logic       sda,
    input  logic       pressed,
    input  logic [3:0] press_idx,
    input  logic       quiet,
    output int         errors,
    output int         groups
);
    import keypad_lcd_pkg::*;

    logic [3:0]  key_q [$];
    logic [3:0]  prev_col;
    logic [3:0]  next_col;
    logic        prev_scl;
    logic        prev_sda;
    logic        prev_pressed;
    logic        in_frame;
    logic        quiet_flagged;
    logic        cur_valid;
    logic [3:0]  cur_key;
    logic [18:0] shift;
    logic [7:0]  want;
    int          bit_cnt;
    int          frame_idx;

    // five backpack bytes for one key position, first frame in the top byte
    function automatic logic [39:0] lcd_bytes(input logic [3:0] idx);
        logic [3:0]  value;
        logic [7:0]  ascii;
        lcd_ctrl_t   c;
        logic [39:0] bytes;
        value = key_map[idx];
        if (value < 4'd10) begin
            ascii = 8'h30 + 8'(value);
        end else begin
            ascii = 8'h41 + 8'(value) - 8'd10;
        end
        for (int i = 0; i < 5; i++) begin
            c.nibble    = (i < 2) ? ascii[7:4] : ascii[3:0];
            c.backlight = lcd_backlight;
            c.en        = (i == 1) || (i == 3);
            c.rw        = 1'b0;
            c.rs        = 1'b1;
            bytes[39 - 8 * i -: 8] = c;
        end
        return bytes;
    endfunction

    //////////////////////////////////////////////////
    // bus decoder, sampled away from the DUT's clock edge

    always @(negedge clk) begin
        if (reset_p) begin
            prev_col      = 4'b0001;
            prev_scl      = 1'b1;
            prev_sda      = 1'b1;
            prev_pressed  = 1'b0;
            in_frame      = 1'b0;
            quiet_flagged = 1'b0;
            cur_valid     = 1'b0;
            frame_idx     = 0;
            errors        = 0;
            groups        = 0;
        end else begin
            // columns are one-hot and step through the pad in order
            next_col = {prev_col[2:0], prev_col[3]};
            if (col != prev_col && col != next_col) begin
                $display("MISMATCH at %0t: col expected %b or %b, got %b",
                         $time, prev_col, next_col, col);
                errors = errors + 1;
            end
            prev_col = col;
            if (quiet && (!scl || !sda) && !quiet_flagged) begin
                $display("error at %0t: bus went active with no key pressed", $time);
                errors        = errors + 1;
                quiet_flagged = 1'b1;
            end
            if (!quiet) begin
                quiet_flagged = 1'b0;
            end
            if (pressed && !prev_pressed) begin
                key_q.push_back(press_idx);
            end
            if (prev_scl && scl && prev_sda && !sda) begin
                // start condition
                if (in_frame) begin
                    $display("error at %0t: start condition inside a frame", $time);
                    errors = errors + 1;
                end
                in_frame = 1'b1;
                bit_cnt  = 0;
                shift    = '0;
                if (frame_idx == 0) begin
                    if (key_q.size() == 0) begin
                        $display("error at %0t: frame group started with no key pressed",
                                 $time);
                        errors    = errors + 1;
                        cur_valid = 1'b0;
                    end else begin
                        cur_key   = key_q.pop_front();
                        cur_valid = 1'b1;
                    end
                end
            end else if (!prev_scl && scl && in_frame) begin
                shift   = {shift[17:0], sda};
                bit_cnt = bit_cnt + 1;
            end else if (prev_scl && scl && !prev_sda && sda && in_frame) begin
                // stop condition closes the frame
                in_frame = 1'b0;
                if (bit_cnt != 19) begin
                    $display("error at %0t: frame had %0d clock pulses instead of 19",
                             $time, bit_cnt);
                    errors = errors + 1;
                end else begin
                    if (shift[18:11] != {lcd_addr, 1'b0}) begin
                        $display("MISMATCH at %0t: sda address byte expected %h, got %h",
                                 $time, {lcd_addr, 1'b0}, shift[18:11]);
                        errors = errors + 1;
                    end
                    if (shift[10] != 1'b1 || shift[1] != 1'b1) begin
                        $display("MISMATCH at %0t: sda ack slots expected 11, got %b%b",
                                 $time, shift[10], shift[1]);
                        errors = errors + 1;
                    end
                    want = lcd_bytes(cur_key) >> (8 * (4 - frame_idx));
                    if (cur_valid && shift[9:2] != want) begin
                        $display("MISMATCH at %0t: sda data byte %0d expected %h, got %h",
                                 $time, frame_idx, want, shift[9:2]);
                        errors = errors + 1;
                    end
                end
                frame_idx = frame_idx + 1;
                if (frame_idx == frames_per_char) begin
                    frame_idx = 0;
                    groups    = groups + 1;
                end
            end
            prev_scl     = scl;
            prev_sda     = sda;
            prev_pressed = pressed;
        end
    end

endmodule

`default_nettype wire

// ==== verif/keypad_lcd_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module keypad_lcd_tb;
    import keypad_lcd_pkg::*;

    localparam int scan_step   = int'(scan_clks);
    localparam int scan_round  = scan_step * num_cols;
    localparam int num_keys    = 16 + 2 + 20 + 4;
    localparam int cycle_limit = 1500 * num_keys + 100;

    logic        clk;
    logic        reset_p;
    logic [3:0]  row = 4'b0000;
    logic [3:0]  col;
    logic        scl;
    logic        sda;
    logic        pressed;
    logic [3:0]  press_idx;
    logic        quiet;
    int          errors;
    int          groups;
    int          cycles = 0;
    int          want_groups;
    int          tests_run;
    int          tests_failed;
    int          errors_before;
    logic [31:0] rand_word;

    tb_clock clock_i (
        .clk     (clk),
        .reset_p (reset_p)
    );

    keypad_lcd_top dut_i (
        .clk     (clk),
        .reset_p (reset_p),
        .row     (row),
        .col     (col),
        .scl     (scl),
        .sda     (sda)
    );

    keypad_lcd_checker checker_i (
        .clk       (clk),
        .reset_p   (reset_p),
        .col       (col),
        .scl       (scl),
        .sda       (sda),
        .pressed   (pressed),
        .press_idx (press_idx),
        .quiet     (quiet),
        .errors    (errors),
        .groups    (groups)
    );

    // keypad matrix, the row answers only while its column is driven
    always @(negedge clk) begin
        if (pressed && col[press_idx[3:2]]) begin
            row <= 4'b0001 << press_idx[1:0];
        end else begin
            row <= 4'b0000;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: no result after %0d cycles, %0d of %0d frame groups seen",
                     cycles, groups, want_groups);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int total_errors();
        return errors + dut_i.writer_i.writer_assert_i.failures;
    endfunction

    task automatic press_key(input logic [3:0] idx, input int hold);
        @(posedge clk);
        press_idx <= idx;
        pressed   <= 1'b1;
        repeat (hold) @(posedge clk);
        pressed <= 1'b0;
    endtask

    task automatic wait_groups(input int n);
        while (groups < n) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = total_errors();
        tests_run  = tests_run + 1;
        if (now_errors == errors_before) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d, %s: FAILED with %0d errors", tests_run, name,
                     now_errors - errors_before);
        end
        errors_before = now_errors;
    endtask

    //////////////////////////////////////////////////
    // stimulus

    initial begin
        pressed       = 1'b0;
        press_idx     = 4'd0;
        quiet         = 1'b0;
        want_groups   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        rand_word     = $urandom(32'h3eae1a48);
        @(posedge clk);
        while (reset_p) @(posedge clk);

        quiet <= 1'b1;
        repeat (500) @(posedge clk);
        quiet <= 1'b0;
        end_test("idle bus after reset");

        for (int i = 0; i < 16; i++) begin
            press_key(4'(i), 2 * scan_round);
            want_groups = want_groups + 1;
            wait_groups(want_groups);
        end
        end_test("all sixteen keys in order");

        // a second group from the held key would arrive with an empty queue
        press_key(4'd9, 10 * scan_step);
        want_groups = want_groups + 1;
        wait_groups(want_groups);
        repeat (300) @(posedge clk);
        press_key(4'd9, 2 * scan_round);
        want_groups = want_groups + 1;
        wait_groups(want_groups);
        end_test("held key then new press");

        for (int i = 0; i < 20; i++) begin
            press_key(4'(rand_word % 16), 2 * scan_round);
            rand_word   = $urandom;
            want_groups = want_groups + 1;
            wait_groups(want_groups);
        end
        end_test("twenty random keys");

        // second key of each pair is captured while frames are still in flight
        for (int p = 0; p < 2; p++) begin
            press_key((p == 0) ? 4'd5 : 4'd15, 2 * scan_round);
            repeat (2 * scan_step) @(posedge clk);
            press_key((p == 0) ? 4'd10 : 4'd0, scan_round);
            want_groups = want_groups + 2;
            wait_groups(want_groups);
        end
        end_test("short press under back-pressure");

        $display("summary: %0d tests, %0d failed, %0d checker errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut_i.writer_i.writer_assert_i.failures);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== keypad_lcd_top.f ====
rtl/keypad_lcd_pkg.sv
rtl/keypad_scanner.sv
rtl/lcd_byte_sender.sv
rtl/i2c_writer.sv
rtl/keypad_lcd_top.sv
verif/tb_clock.sv
verif/i2c_writer_assert.sv
verif/keypad_lcd_checker.sv
verif/keypad_lcd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the keypad to LCD simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module keypad_lcd_tb \
    -f keypad_lcd_top.f \
    -o keypad_lcd_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/keypad_lcd_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
